// File: hw/video_timing_pkg.sv
// Raster geometry, sync positions and pixel divider shared by the timing RTL and its testbench
`default_nettype none

package video_timing_pkg;

    // Counter types
    typedef logic [8:0] hcount_t;   // Pixel position within a line
    typedef logic [8:0] vcount_t;   // Line number within a frame

    // Horizontal geometry in pixels
    localparam logic [9:0] H_TOTAL   = 10'd320;  // Line runs 0 to 319
    localparam hcount_t    H_ACTIVE  = 9'd256;   // Blank from here to end of line
    localparam hcount_t    HBD_DELAY = 9'd8;     // Extra pixels before DMA blank
    localparam hcount_t    HS_START  = 9'd280;   // First count with hs high
    localparam hcount_t    HS_END    = 9'd304;   // First count with hs low again

    // Vertical geometry in lines
    localparam vcount_t    V_TOTAL   = 9'd263;   // Frame runs 0 to 262
    localparam vcount_t    V_ACTIVE  = 9'd224;   // Blank from here to end of frame
    localparam vcount_t    VS_START  = 9'd232;
    localparam vcount_t    VS_END    = 9'd235;   // Three lines of vs

    // Master clock to pixel ratio
    // Must be a power of two and at least 4
    localparam int unsigned CEN_DIV  = 4;
    localparam int unsigned CEN_W    = $clog2(CEN_DIV);  // Divider counter width

endpackage

`default_nettype wire

// File: hw/prom_pkg.sv
// Shape and bit map of the raster timing PROM, used by the PROM, the counters and the testbench
`default_nettype none

package prom_pkg;

    localparam int PROM_AW    = 8;               // Address bits
    localparam int PROM_DW    = 4;               // Data bits
    localparam int PROM_DEPTH = 1 << PROM_AW;    // 256 words

    typedef logic [PROM_AW-1:0] prom_addr_t;     // {hb, hcount[7:1]}
    typedef logic [PROM_DW-1:0] prom_data_t;

    // Data bit that advances the line counter
    // Only the rising edge of this bit counts
    localparam int PROM_BIT_LINE = 1;

endpackage

`default_nettype wire

// File: hw/pixel_cen_gen.sv
// Clock-enable divider giving the pixel strobe and the double-rate sprite strobe from clk
`timescale 1ns/1ps
`default_nettype none

module pixel_cen_gen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl_cen,    // One clk in every CEN_DIV
    output logic pxl2_cen    // Twice per pixel for the sprite path
);
    import video_timing_pkg::*;

    // Free-running phase counter
    logic [CEN_W-1:0] div_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;   // Wraps naturally at CEN_DIV
        end
    end

    // Half-period strobe
    // Fires when the low bits are all ones, so at CEN_DIV/2-1 and CEN_DIV-1
    assign pxl2_cen = &div_cnt[CEN_W-2:0];

    // Full wrap strobe
    // Always lands on the second pxl2_cen of the period
    assign pxl_cen  = &div_cnt;      // Low while div_cnt is in reset

endmodule

`default_nettype wire

// File: hw/timing_prom.sv
// Loadable stand-in for the board's raster timing PROM, written from the programming port
`timescale 1ns/1ps
`default_nettype none

module timing_prom (
    input  logic                 clk,
    input  prom_pkg::prom_addr_t prog_addr,   // Load address
    input  logic                 prom_we,     // One word per clk while high
    input  prom_pkg::prom_data_t prom_din,
    input  prom_pkg::prom_addr_t rd_addr,     // From the raster counters
    output prom_pkg::prom_data_t q            // Valid one clk after rd_addr
);
    import prom_pkg::*;

    // Word storage
    // Fuse map of the real part is loaded at start-up
    prom_data_t mem [PROM_DEPTH];

    // Programming side
    always_ff @(posedge clk) begin
        if (prom_we) begin
            mem[prog_addr] <= prom_din;
        end
    end

    // Read side
    // Registered like a block RAM output
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];           // Old data on a same-address write
    end

endmodule

`default_nettype wire

// File: hw/raster_counters.sv
// Horizontal and line counters with blanking, sync and screen flip for the arcade raster
`timescale 1ns/1ps
`default_nettype none

module raster_counters (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pxl_cen,     // Advances the pixel count
    input  logic                 pxl2_cen,    // Samples the PROM line bit
    input  logic                 rv_n,        // Flip, active low
    input  prom_pkg::prom_data_t prom_data,   // PROM word for prom_addr
    output prom_pkg::prom_addr_t prom_addr,
    output logic [7:0]           h,           // Exported position
    output logic [7:0]           v,
    output logic                 h2o,
    output logic                 hb,          // Horizontal blank
    output logic                 hbd_n,       // Late part of blank for DMA
    output logic                 vb,          // Vertical blank
    output logic                 initeo_n,
    output logic                 hs,
    output logic                 vs,
    output logic                 sy_n         // Composite sync
);
    import video_timing_pkg::*;
    import prom_pkg::*;

    // Decode points
    localparam hcount_t H_LAST    = hcount_t'(H_TOTAL - 10'd1);
    localparam hcount_t HBD_START = H_ACTIVE + HBD_DELAY;   // hbd_n falls here
    localparam vcount_t V_LAST    = V_TOTAL - 9'd1;

    logic    flip;
    hcount_t hcount;        // Pixel in line
    hcount_t hcount_nxt;
    vcount_t line;          // Line in frame
    vcount_t line_nxt;
    logic    line_up;       // PROM line bit
    logic    line_up_l;     // Same bit on the previous pxl2_cen
    logic    hs_dec;
    logic    vs_dec;

    assign flip = ~rv_n;

    // Horizontal counter
    assign hcount_nxt = (hcount == H_LAST) ? '0 : hcount + 9'd1;

    // Blank flags decode the next count so they change with it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            hb     <= 1'b0;
            hbd_n  <= 1'b1;
        end else if (pxl_cen) begin
            hcount <= hcount_nxt;
            hb     <= (hcount_nxt >= H_ACTIVE);
            hbd_n  <= (hcount_nxt < HBD_START);    // Low for the tail of blank
        end
    end

    // PROM lookup
    // Two pixels per word, blank half in the upper 128 words
    assign prom_addr = {hb, hcount[7:1]};

    // Line counter
    assign line_up  = prom_data[PROM_BIT_LINE];
    assign line_nxt = (line == V_LAST) ? '0 : line + 9'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line      <= '0;
            vb        <= 1'b0;
            line_up_l <= 1'b0;
        end else if (pxl2_cen) begin
            line_up_l <= line_up;
            if (line_up && !line_up_l) begin       // Rising edge of the strobe
                line <= line_nxt;
                vb   <= (line_nxt >= V_ACTIVE);
            end
        end
    end

    // Sync decode
    assign hs_dec = (hcount >= HS_START) && (hcount < HS_END);
    assign vs_dec = (line >= VS_START) && (line < VS_END);

    // One clk behind the counts
    // Composite is taken from the same decodes so it never lags hs or vs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs   <= 1'b0;
            vs   <= 1'b0;
            sy_n <= 1'b1;
        end else begin
            hs   <= hs_dec;
            vs   <= vs_dec;
            sy_n <= ~(hs_dec ^ vs_dec);   // Serrated during vs
        end
    end

    // Flip handling on the exported position
    // Low three bits keep counting up so pixel order in a byte holds
    assign h        = {hcount[7:3] ^ {5{flip}}, hcount[2:0]};
    assign h2o      = hcount[2] ^ flip;
    assign v        = line[7:0] ^ {8{flip}};
    assign initeo_n = ~(flip ^ hb);        // Swaps even and odd line init

endmodule

`default_nettype wire

// File: hw/dma_interleave.sv
// Sprite DMA window logic that requests the bus and clocks transfers during vertical blank
`timescale 1ns/1ps
`default_nettype none

module dma_interleave (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       vb,        // Vertical blank
    input  logic [1:0] h_low,     // Pixel phase within four
    input  logic       dm10,      // DMA demand from the CPU side
    input  logic       busak,     // CPU has released the bus
    input  logic       hbd_n,     // Resting level of the transfer clock
    output logic       rohvs,     // Start of window, one pixel
    output logic       rohvck,    // Transfer clock
    output logic       mr_n       // Bus request, active low
);

    logic win_open;
    logic win_l;      // Window state one pixel back

    // Transfers only while blank, demand and grant all hold
    assign win_open = vb & dm10 & busak;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_l  <= 1'b0;
            mr_n   <= 1'b1;
            rohvs  <= 1'b0;
            rohvck <= 1'b0;
        end else if (pxl_cen) begin
            win_l <= win_open;

            // Ask for the bus as soon as demand meets blank
            mr_n  <= ~(vb & dm10);

            // Start strobe on the first open pixel
            rohvs <= win_open & ~win_l;

            // One clock edge every fourth pixel inside the window
            // Closed window during blank rests at hbd_n and is 0 outside blank
            if (win_open) begin
                rohvck <= (h_low == 2'd3);
            end else begin
                rohvck <= vb & hbd_n;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/video_timing_top.sv
// Top of the video timing subsystem, joining the pixel divider, timing PROM, counters and DMA window
`timescale 1ns/1ps
`default_nettype none

module video_timing_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rv_n,        // Screen flip, active low
    input  logic                 dm10,
    input  logic                 busak,
    input  prom_pkg::prom_addr_t prog_addr,   // PROM load port
    input  logic                 prom_we,
    input  prom_pkg::prom_data_t prom_din,
    output logic                 pxl_cen,     // Pixel enable for the display side
    output logic [7:0]           h,
    output logic [7:0]           v,
    output logic                 h2o,
    output logic                 hb,
    output logic                 hbd_n,
    output logic                 vb,
    output logic                 initeo_n,
    output logic                 hs,
    output logic                 vs,
    output logic                 sy_n,
    output logic                 rohvs,
    output logic                 rohvck,
    output logic                 mr_n
);
    import prom_pkg::*;

    logic       pxl2_cen;
    prom_addr_t prom_addr;    // Counter position into the PROM
    prom_data_t prom_data;

    pixel_cen_gen pixel_cen_gen_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen)
    );

    timing_prom timing_prom_i (
        .clk       (clk),
        .prog_addr (prog_addr),
        .prom_we   (prom_we),
        .prom_din  (prom_din),
        .rd_addr   (prom_addr),
        .q         (prom_data)
    );

    raster_counters raster_counters_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .pxl2_cen  (pxl2_cen),
        .rv_n      (rv_n),
        .prom_data (prom_data),
        .prom_addr (prom_addr),
        .h         (h),
        .v         (v),
        .h2o       (h2o),
        .hb        (hb),
        .hbd_n     (hbd_n),
        .vb        (vb),
        .initeo_n  (initeo_n),
        .hs        (hs),
        .vs        (vs),
        .sy_n      (sy_n)
    );

    // Low pixel bits are not flipped so the transfer phase is the same either way
    dma_interleave dma_interleave_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .vb      (vb),
        .h_low   (h[1:0]),
        .dm10    (dm10),
        .busak   (busak),
        .hbd_n   (hbd_n),
        .rohvs   (rohvs),
        .rohvck  (rohvck),
        .mr_n    (mr_n)
    );

endmodule

`default_nettype wire

// File: bench/video_model.svh
// Reference rules for the raster outputs, included inside the testbench module after its imports
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

// Pixel count after one pixel strobe
function automatic hcount_t next_hcount(input hcount_t hc);
    return (int'(hc) + 1 == int'(H_TOTAL)) ? '0 : hc + 9'd1;
endfunction

// Line number after one line strobe
function automatic vcount_t next_line(input vcount_t ln);
    return (int'(ln) + 1 == int'(V_TOTAL)) ? '0 : ln + 9'd1;
endfunction

// Line held by the counter once the pixel count has reached from
// The strobe lands a few clks into blank, so lines change mid-line
function automatic vcount_t line_seen(input vcount_t ln, input hcount_t hc, input hcount_t from);
    return (hc >= from) ? next_line(ln) : ln;
endfunction

// Exported position with the flip applied, bit 8 always zero
function automatic hcount_t h_out(input hcount_t hc, input logic flip);
    return {1'b0, hc[7:3] ^ {5{flip}}, hc[2:0]};   // Low three bits never flip
endfunction

function automatic logic h2o_out(input hcount_t hc, input logic flip);
    return hc[2] ^ flip;
endfunction

function automatic vcount_t v_out(input vcount_t ln, input logic flip);
    return {1'b0, ln[7:0] ^ {8{flip}}};
endfunction

// Blank levels
function automatic logic blank_h(input hcount_t hc);
    return hc >= H_ACTIVE;
endfunction

function automatic logic blank_dma_n(input hcount_t hc);
    return hc < (H_ACTIVE + HBD_DELAY);          // Falls HBD_DELAY pixels into blank
endfunction

function automatic logic blank_v(input vcount_t ln);
    return ln >= V_ACTIVE;
endfunction

// Sync levels
function automatic logic hsync_on(input hcount_t hc);
    return (hc >= HS_START) && (hc < HS_END);
endfunction

function automatic logic vsync_on(input vcount_t ln);
    return (ln >= VS_START) && (ln < VS_END);
endfunction

function automatic logic csync_n(input logic hsync, input logic vsync);
    return ~(hsync ^ vsync);
endfunction

function automatic logic init_eo_n(input logic hblank, input logic flip);
    return ~(flip ^ hblank);
endfunction

// DMA window rules
function automatic logic window_open(input logic vblank, input logic dm, input logic ak);
    return vblank & dm & ak;
endfunction

function automatic logic bus_req_n(input logic vblank, input logic dm);
    return ~(vblank & dm);
endfunction

// Transfer clock on phase 3, otherwise idle at hbd_n inside blank
function automatic logic xfer_clk(input logic win, input hcount_t hc, input logic vblank);
    return win ? (hc[1:0] == 2'b11) : (vblank & blank_dma_n(hc));
endfunction

// PROM load image, line bit only at the first blank words
function automatic prom_data_t prom_pattern(input prom_addr_t a);
    prom_data_t w;
    w = '0;
    if (a >= 8'd128 && a <= 8'd131) begin
        w[PROM_BIT_LINE] = 1'b1;
    end
    return w;
endfunction

`endif

// File: bench/video_tb.sv
// Self-checking testbench for the video timing top, compiled from the project root with all.f
`timescale 1ns/1ps
`default_nettype none

module video_tb;
    import video_timing_pkg::*;
    import prom_pkg::*;

    localparam int  CLK_PERIOD  = 100;
    localparam int  DRV_DLY     = 10;    // Input drive after the rising edge
    localparam int  RST_CYCLES  = 5;
    localparam int  RUN_FRAMES  = 2;
    localparam real WATCHDOG_NS = 3.0 * H_TOTAL * V_TOTAL * CEN_DIV * CLK_PERIOD;

    // DUT inputs
    logic       clk;
    logic       rst_n;
    logic       rv_n;
    logic       dm10;
    logic       busak;
    prom_addr_t prog_addr;
    logic       prom_we;
    prom_data_t prom_din;

    // DUT outputs
    logic       pxl_cen;
    logic [7:0] h;
    logic [7:0] v;
    logic       h2o;
    logic       hb;
    logic       hbd_n;
    logic       vb;
    logic       initeo_n;
    logic       hs;
    logic       vs;
    logic       sy_n;
    logic       rohvs;
    logic       rohvck;
    logic       mr_n;

    // Run control
    int      seed       = 53037;
    bit      started    = 1'b0;  // Set once reset is first asserted
    int      edges      = 0;     // Rising edges since reset release
    int      frames     = 0;
    int      flips_done = 0;

    // Model counters
    int      m_div    = 0;
    hcount_t m_h      = '0;
    vcount_t m_line   = '0;      // Line at the start of the current line
    bit      m_win    = 1'b0;
    bit      sync_due = 1'b0;    // Sync check pending one clk after a pixel edge
    logic    exp_mr_n   = 1'b1;
    logic    exp_rohvs  = 1'b0;
    logic    exp_rohvck = 1'b0;

    // For the coming pixel edge
    logic    nxt_mr_n;
    logic    nxt_rohvs;
    logic    nxt_rohvck;
    logic    nxt_win;

    `include "video_model.svh"

    video_timing_top video_timing_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_h(input string name, input hcount_t exp, input hcount_t act);
        if (exp !== act) begin
            fail_run($sformatf("Mismatch %s expected %0d actual %0d at %0t",
                               name, exp, act, $time));
        end
    endtask

    task automatic check_v(input string name, input vcount_t exp, input vcount_t act);
        if (exp !== act) begin
            fail_run($sformatf("Mismatch %s expected %0d actual %0d at %0t",
                               name, exp, act, $time));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("Mismatch %s expected %b actual %b at %0t",
                               name, exp, act, $time));
        end
    endtask

    // One word per clk through the programming port
    task automatic load_prom();
        for (int a = 0; a < PROM_DEPTH; a++) begin
            @(posedge clk);
            #DRV_DLY;
            prog_addr = prom_addr_t'(a);
            prom_din  = prom_pattern(prom_addr_t'(a));
            prom_we   = 1'b1;
        end
        @(posedge clk);
        #DRV_DLY;
        prom_we = 1'b0;
    endtask

    // Outputs during reset and before the first edge after release
    task automatic expect_idle_state();
        check_bit("pxl_cen in reset", 1'b0, pxl_cen);
        check_h("h in reset", h_out('0, ~rv_n), {1'b0, h});
        check_v("v in reset", v_out('0, ~rv_n), {1'b0, v});
        check_bit("hb in reset", 1'b0, hb);
        check_bit("hbd_n in reset", 1'b1, hbd_n);
        check_bit("vb in reset", 1'b0, vb);
        check_bit("hs in reset", 1'b0, hs);
        check_bit("vs in reset", 1'b0, vs);
        check_bit("sy_n in reset", 1'b1, sy_n);
        check_bit("initeo_n in reset", init_eo_n(1'b0, ~rv_n), initeo_n);
        check_bit("mr_n in reset", 1'b1, mr_n);
        check_bit("rohvs in reset", 1'b0, rohvs);
        check_bit("rohvck in reset", 1'b0, rohvck);
    endtask

    // DMA results for the pixel edge that follows this clk
    task automatic plan_dma();
        logic vb_now;
        vb_now     = blank_v(line_seen(m_line, m_h, H_ACTIVE));
        nxt_win    = window_open(vb_now, dm10, busak);
        nxt_mr_n   = bus_req_n(vb_now, dm10);
        nxt_rohvs  = nxt_win & ~m_win;        // First open pixel only
        nxt_rohvck = xfer_clk(nxt_win, m_h, vb_now);
    endtask

    // Advance the model by one clk edge and compare
    task automatic step_model();
        bit      was_pxl;
        vcount_t sync_line;
        was_pxl = (m_div == CEN_DIV - 1);
        m_div   = (m_div + 1) % CEN_DIV;
        if (sync_due) begin
            sync_line = line_seen(m_line, m_h, H_ACTIVE + 9'd1);
            check_bit("hs", hsync_on(m_h), hs);
            check_bit("vs", vsync_on(sync_line), vs);
            check_bit("sy_n", csync_n(hsync_on(m_h), vsync_on(sync_line)), sy_n);
            sync_due = 1'b0;
        end
        if (was_pxl) begin
            m_h        = next_hcount(m_h);
            exp_mr_n   = nxt_mr_n;
            exp_rohvs  = nxt_rohvs;
            exp_rohvck = nxt_rohvck;
            m_win      = nxt_win;
            sync_due   = 1'b1;
            if (m_h == '0) begin               // Start of a new line
                m_line = next_line(m_line);
                if (m_line == '0) begin
                    frames++;
                end
                check_v("v at line start", v_out(m_line, ~rv_n), {1'b0, v});
                check_bit("vb at line start", blank_v(m_line), vb);
            end
        end
        check_bit("pxl_cen spacing", m_div == CEN_DIV - 1, pxl_cen);
        check_h("h", h_out(m_h, ~rv_n), {1'b0, h});
        check_bit("h2o", h2o_out(m_h, ~rv_n), h2o);
        check_bit("hb", blank_h(m_h), hb);
        check_bit("hbd_n", blank_dma_n(m_h), hbd_n);
        check_bit("initeo_n", init_eo_n(blank_h(m_h), ~rv_n), initeo_n);
        check_bit("mr_n", exp_mr_n, mr_n);
        check_bit("rohvs", exp_rohvs, rohvs);
        check_bit("rohvck", exp_rohvck, rohvck);
        if (m_div == CEN_DIV - 1) begin
            plan_dma();
        end
    endtask

    always @(posedge clk) begin
        if (started && rst_n) begin
            edges <= edges + 1;
        end
    end

    // Compare at the falling edge where all outputs are settled
    always @(negedge clk) begin
        if (started) begin
            if (edges == 0) begin
                expect_idle_state();
            end else begin
                step_model();
            end
        end
    end

    // Random demand and grant per pixel, flip toggled at each new frame
    always @(posedge clk) begin
        int rnd;
        #DRV_DLY;
        if (started && rst_n && pxl_cen) begin
            rnd   = $random(seed);
            dm10  = rnd[0] | rnd[1];          // High three pixels in four
            busak = rnd[2] | rnd[3];
        end
        if (frames != flips_done) begin
            rv_n       = ~rv_n;
            flips_done = frames;
        end
    end

    initial begin
        rst_n     = 1'b1;
        rv_n      = 1'b1;
        dm10      = 1'b0;
        busak     = 1'b0;
        prog_addr = '0;
        prom_we   = 1'b0;
        prom_din  = '0;
        load_prom();                          // Fuse image goes in before the counters start
        @(posedge clk);
        #DRV_DLY;
        rst_n   = 1'b0;
        started = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;
        wait (frames >= RUN_FRAMES);
        @(posedge clk);                       // Away from the compare edge
        $display("test passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("Watchdog expired before two video frames completed");
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+bench
hw/video_timing_pkg.sv
hw/prom_pkg.sv
hw/pixel_cen_gen.sv
hw/timing_prom.sv
hw/raster_counters.sv
hw/dma_interleave.sv
hw/video_timing_top.sv
bench/video_tb.sv
